//--- verilog/erx_pkg.sv
// ##########################################################################
// erx register block shared definitions
// widths, register word indices and bridge FSM states
// ##########################################################################

package erx_pkg;

   // ########################################################################
   // data widths
   // ########################################################################
   typedef logic [31:0] data_t;     // register and packet data word
   typedef logic [31:0] addr_t;     // full link address
   typedef logic [14:0] mi_addr_t;  // memory interface byte address
   typedef logic [44:0] tap_t;      // 9 pins x 5 tap bits

   // ########################################################################
   // register word indices, decoded from addr[rfaw+1:2]
   // ########################################################################
   localparam int unsigned reg_cfg      = 0;  // mode bits, remap fields
   localparam int unsigned reg_offset   = 1;  // dynamic remap base
   localparam int unsigned reg_idelay0  = 2;  // taps, low nibbles
   localparam int unsigned reg_idelay1  = 3;  // taps, msbs and frame nibble
   localparam int unsigned reg_testdata = 4;  // test mode accumulator
   localparam int unsigned reg_status   = 5;  // sticky rx status
   localparam int unsigned reg_gpio     = 6;  // sampled pins

   // ########################################################################
   // host bridge FSM
   // ########################################################################
   typedef enum logic [1:0] {
      idle,        // no host cycle in flight
      wait_grant,  // request held toward arbiter
      ack          // read data capture, then one-cycle ack
   } bridge_state_t;

endpackage

//--- verilog/erx_wb_bridge.sv
// ##########################################################################
// wishbone classic slave bridge
// turns host cycles into memory interface requests, acks once per cycle
// ##########################################################################

module erx_wb_bridge (
   input  logic                clk,
   input  logic                nreset,
   // wishbone slave
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  erx_pkg::mi_addr_t   wb_adr,
   input  erx_pkg::data_t      wb_dat_i,
   output erx_pkg::data_t      wb_dat_o,
   output logic                wb_ack,
   // requester side toward arbiter
   output logic                req,
   output logic                we,
   output erx_pkg::mi_addr_t   addr,
   output erx_pkg::data_t      din,
   input  logic                gnt,
   // registered read data from the register file
   input  erx_pkg::data_t      mi_dout
);

   erx_pkg::bridge_state_t state;
   logic                   rd_wait;  // read granted, data one cycle away

   // host holds its fields for the whole cycle, pass them on as is
   assign req    = (state == erx_pkg::wait_grant);
   assign we     = wb_we;
   assign addr   = wb_adr;
   assign din    = wb_dat_i;
   assign wb_ack = (state == erx_pkg::ack) & ~rd_wait;  // single pulse

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state   <= erx_pkg::idle;
         rd_wait <= 1'b0;
      end else begin
         case (state)
            erx_pkg::idle: begin
               if (wb_cyc & wb_stb)
                  state <= erx_pkg::wait_grant;
            end
            erx_pkg::wait_grant: begin
               if (gnt) begin
                  state   <= erx_pkg::ack;
                  rd_wait <= ~wb_we;  // reads take one extra cycle
               end
            end
            erx_pkg::ack: begin
               if (rd_wait)
                  rd_wait <= 1'b0;    // mi_dout valid now, ack next
               else
                  state   <= erx_pkg::idle;
            end
            default: state <= erx_pkg::idle;
         endcase
      end
   end

   // capture read data so it stays valid through the ack cycle
   always_ff @(posedge clk) begin
      if ((state == erx_pkg::ack) && rd_wait)
         wb_dat_o <= mi_dout;
   end

endmodule

//--- verilog/erx_pkt_access.sv
// ##########################################################################
// link packet input stage
// splits chip-id register writes from data packets, applies test mode
// ##########################################################################

module erx_pkt_access #(
   parameter logic [11:0] chip_id = 12'h810
) (
   input  logic                clk,
   input  logic                nreset,
   // packet input
   input  logic                pkt_valid,
   output logic                pkt_ready,
   input  erx_pkg::addr_t      pkt_addr,
   input  erx_pkg::data_t      pkt_data,
   // register write requester, always a write
   output logic                req,
   output erx_pkg::mi_addr_t   addr,
   output erx_pkg::data_t      din,
   input  logic                gnt,
   // test mode
   input  logic                test_mode,
   output logic                test_access,
   output erx_pkg::data_t      test_data,
   // forwarded data packets toward remapper
   output logic                fwd_valid,
   output erx_pkg::addr_t      fwd_addr,
   output erx_pkg::data_t      fwd_data
);

   logic              xfer;       // packet accepted this edge
   logic              is_reg;     // address targets this chip
   logic              pend;       // register write waiting for grant
   erx_pkg::mi_addr_t pend_addr;
   erx_pkg::data_t    pend_data;

   assign xfer      = pkt_valid & pkt_ready;
   assign is_reg    = (pkt_addr[31:20] == chip_id);
   assign pkt_ready = ~pend;  // stall while a register write is held

   assign req  = pend;
   assign addr = pend_addr;
   assign din  = pend_data;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         pend <= 1'b0;
      else if (xfer & is_reg)
         pend <= 1'b1;
      else if (gnt)
         pend <= 1'b0;          // write lands on this edge
   end

   always_ff @(posedge clk) begin
      if (xfer & is_reg) begin
         pend_addr <= pkt_addr[14:0];  // byte address inside the block
         pend_data <= pkt_data;
      end
   end

   // data packets go straight to the remapper, which registers them
   assign fwd_valid = xfer & ~is_reg & ~test_mode;
   assign fwd_addr  = pkt_addr;
   assign fwd_data  = pkt_data;

   // test mode swallows data packets into the accumulator
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         test_access <= 1'b0;
      else
         test_access <= xfer & ~is_reg & test_mode;
   end

   always_ff @(posedge clk) begin
      test_data <= pkt_data;    // qualified by test_access
   end

endmodule

//--- verilog/erx_mi_arbiter.sv
// ##########################################################################
// round-robin memory interface arbiter
// host and link requesters share one register file port
// ##########################################################################

module erx_mi_arbiter (
   input  logic                clk,
   input  logic                nreset,
   // host requester
   input  logic                host_req,
   input  logic                host_we,
   input  erx_pkg::mi_addr_t   host_addr,
   input  erx_pkg::data_t      host_din,
   output logic                host_gnt,
   // link requester, write only
   input  logic                link_req,
   input  erx_pkg::mi_addr_t   link_addr,
   input  erx_pkg::data_t      link_din,
   output logic                link_gnt,
   // shared memory interface
   output logic                mi_en,
   output logic                mi_we,
   output erx_pkg::mi_addr_t   mi_addr,
   output erx_pkg::data_t      mi_din
);

   logic last_link;  // 1 when the link side won the last grant

   // on a tie the side that lost last time goes first
   assign host_gnt = host_req & (~link_req | last_link);
   assign link_gnt = link_req & (~host_req | ~last_link);

   // ########################################################################
   // memory interface mux, same cycle as grant
   // ########################################################################
   assign mi_en   = host_gnt | link_gnt;
   assign mi_we   = link_gnt | (host_gnt & host_we);  // link always writes
   assign mi_addr = link_gnt ? link_addr : host_addr;
   assign mi_din  = link_gnt ? link_din  : host_din;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         last_link <= 1'b0;
      else if (mi_en)
         last_link <= link_gnt;
   end

endmodule

//--- verilog/erx_cfg.sv
// ##########################################################################
// receive configuration register file
// decode, sticky status, test accumulator, tap packing and readback
// ##########################################################################

module erx_cfg #(
   parameter logic [3:0] group = 4'h0,
   parameter int         rfaw  = 6
) (
   input  logic                clk,
   input  logic                nreset,
   // memory interface
   input  logic                mi_en,
   input  logic                mi_we,
   input  erx_pkg::mi_addr_t   mi_addr,
   input  erx_pkg::data_t      mi_din,
   output erx_pkg::data_t      mi_dout,
   // status and pins
   input  logic [8:0]          gpio_datain,
   input  logic [15:0]         rx_status,
   // test interface
   input  logic                test_access,
   input  erx_pkg::data_t      test_data,
   // config outputs
   output logic                test_mode,
   output logic [1:0]          remap_mode,
   output logic [11:0]         remap_sel,
   output logic [11:0]         remap_pattern,
   output erx_pkg::data_t      remap_base,
   output erx_pkg::tap_t       idelay_value,
   output logic                load_taps
);

   erx_pkg::data_t  cfg_reg;      // bits 1 and 29:28 kept for mmu and timer
   erx_pkg::data_t  offset_reg;
   erx_pkg::data_t  testdata_reg;
   logic [15:0]     status_reg;
   logic [8:0]      gpio_reg;
   erx_pkg::tap_t   idelay;       // raw idelay0/idelay1 contents

   logic            hit;          // group match
   logic [rfaw-1:0] idx;          // register word index
   logic            wr;
   logic            rd;

   // ########################################################################
   // address decode
   // ########################################################################
   assign hit = (mi_addr[11:8] == group);
   assign idx = mi_addr[rfaw+1:2];
   assign wr  = mi_en & mi_we & hit;
   assign rd  = mi_en & ~mi_we & hit;  // wrong group reads zero

   // ########################################################################
   // writable registers
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg_reg      <= '0;
         offset_reg   <= '0;
         testdata_reg <= '0;
         status_reg   <= '0;
         idelay       <= '0;
      end else begin
         if (wr && idx == erx_pkg::reg_cfg)
            cfg_reg <= mi_din;
         if (wr && idx == erx_pkg::reg_offset)
            offset_reg <= mi_din;
         // write wins over accumulate
         if (wr && idx == erx_pkg::reg_testdata)
            testdata_reg <= mi_din;
         else if (test_access)
            testdata_reg <= testdata_reg + test_data;  // wraps mod 2^32
         // sticky, a write replaces
         if (wr && idx == erx_pkg::reg_status)
            status_reg <= mi_din[15:0];
         else
            status_reg <= status_reg | rx_status;
         if (wr && idx == erx_pkg::reg_idelay0)
            idelay[31:0] <= mi_din;
         if (wr && idx == erx_pkg::reg_idelay1)
            idelay[44:32] <= mi_din[12:0];
      end
   end

   // pins sampled every cycle, load strobe one cycle after idelay1 write
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         gpio_reg  <= '0;
         load_taps <= 1'b0;
      end else begin
         gpio_reg  <= gpio_datain;
         load_taps <= wr && (idx == erx_pkg::reg_idelay1);
      end
   end

   // ########################################################################
   // config fields
   // ########################################################################
   assign test_mode     = cfg_reg[0];
   assign remap_mode    = cfg_reg[3:2];
   assign remap_sel     = cfg_reg[15:4];
   assign remap_pattern = cfg_reg[27:16];
   assign remap_base    = offset_reg;

   // per pin, d0 up to frame: msb from idelay1, nibble from the low words
   always_comb begin
      for (int i = 0; i < 9; i++)
         idelay_value[5*i +: 5] = {idelay[36+i], idelay[4*i +: 4]};
   end

   // ########################################################################
   // readback, one cycle latency
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         mi_dout <= '0;
      else if (rd) begin
         case (idx)
            erx_pkg::reg_cfg:      mi_dout <= cfg_reg;
            erx_pkg::reg_offset:   mi_dout <= offset_reg;
            erx_pkg::reg_testdata: mi_dout <= testdata_reg;
            erx_pkg::reg_status:   mi_dout <= {16'b0, status_reg};
            erx_pkg::reg_gpio:     mi_dout <= {23'b0, gpio_reg};
            default:               mi_dout <= '0;  // idelay is write only
         endcase
      end else
         mi_dout <= '0;
   end

endmodule

//--- verilog/erx_remap.sv
// ##########################################################################
// forwarded packet address remapper
// static bit-select or dynamic base offset, registered output
// ##########################################################################

module erx_remap (
   input  logic             clk,
   input  logic             nreset,
   input  logic             fwd_valid,
   input  erx_pkg::addr_t   fwd_addr,
   input  erx_pkg::data_t   fwd_data,
   input  logic [1:0]       remap_mode,     // 0 none, 1 static, 2 dynamic
   input  logic [11:0]      remap_sel,
   input  logic [11:0]      remap_pattern,
   input  erx_pkg::data_t   remap_base,
   output logic             out_valid,
   output erx_pkg::addr_t   out_addr,
   output erx_pkg::data_t   out_data
);

   erx_pkg::addr_t new_addr;

   always_comb begin
      case (remap_mode)
         2'd1: new_addr = {(fwd_addr[31:20] & ~remap_sel) | (remap_pattern & remap_sel),
                           fwd_addr[19:0]};
         2'd2: new_addr = fwd_addr + remap_base;
         default: new_addr = fwd_addr;  // mode 3 behaves as none
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         out_valid <= 1'b0;
      else
         out_valid <= fwd_valid;
   end

   always_ff @(posedge clk) begin
      if (fwd_valid) begin
         out_addr <= new_addr;
         out_data <= fwd_data;
      end
   end

endmodule

//--- verilog/erx_regs_top.sv
// ##########################################################################
// erx register block top level
// host bridge, packet stage, arbiter, register file and remapper
// ##########################################################################

module erx_regs_top #(
   parameter logic [11:0] chip_id = 12'h810,
   parameter logic [3:0]  group   = 4'h0,
   parameter int          rfaw    = 6
) (
   input  logic                clk,
   input  logic                nreset,
   // wishbone host port
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  erx_pkg::mi_addr_t   wb_adr,
   input  erx_pkg::data_t      wb_dat_i,
   output erx_pkg::data_t      wb_dat_o,
   output logic                wb_ack,
   // link packets in
   input  logic                pkt_valid,
   output logic                pkt_ready,
   input  erx_pkg::addr_t      pkt_addr,
   input  erx_pkg::data_t      pkt_data,
   // remapped packets out
   output logic                out_valid,
   output erx_pkg::addr_t      out_addr,
   output erx_pkg::data_t      out_data,
   // pins and io delay
   input  logic [8:0]          gpio_datain,
   input  logic [15:0]         rx_status,
   output erx_pkg::tap_t       idelay_value,
   output logic                load_taps
);

   // host requester
   logic              host_req, host_we, host_gnt;
   erx_pkg::mi_addr_t host_addr;
   erx_pkg::data_t    host_din;
   // link requester
   logic              link_req, link_gnt;
   erx_pkg::mi_addr_t link_addr;
   erx_pkg::data_t    link_din;
   // memory interface
   logic              mi_en, mi_we;
   erx_pkg::mi_addr_t mi_addr;
   erx_pkg::data_t    mi_din, mi_dout;
   // config and test
   logic              test_mode, test_access;
   erx_pkg::data_t    test_data, remap_base;
   logic [1:0]        remap_mode;
   logic [11:0]       remap_sel, remap_pattern;
   // forwarded packets
   logic              fwd_valid;
   erx_pkg::addr_t    fwd_addr;
   erx_pkg::data_t    fwd_data;

   erx_wb_bridge erx_wb_bridge_i (
      .clk, .nreset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
      .req(host_req), .we(host_we), .addr(host_addr), .din(host_din), .gnt(host_gnt),
      .mi_dout
   );

   erx_pkt_access #(.chip_id(chip_id)) erx_pkt_access_i (
      .clk, .nreset, .pkt_valid, .pkt_ready, .pkt_addr, .pkt_data,
      .req(link_req), .addr(link_addr), .din(link_din), .gnt(link_gnt),
      .test_mode, .test_access, .test_data, .fwd_valid, .fwd_addr, .fwd_data
   );

   erx_mi_arbiter erx_mi_arbiter_i (
      .clk, .nreset, .host_req, .host_we, .host_addr, .host_din, .host_gnt,
      .link_req, .link_addr, .link_din, .link_gnt,
      .mi_en, .mi_we, .mi_addr, .mi_din
   );

   erx_cfg #(.group(group), .rfaw(rfaw)) erx_cfg_i (
      .clk, .nreset, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
      .gpio_datain, .rx_status, .test_access, .test_data,
      .test_mode, .remap_mode, .remap_sel, .remap_pattern, .remap_base,
      .idelay_value, .load_taps
   );

   erx_remap erx_remap_i (
      .clk, .nreset, .fwd_valid, .fwd_addr, .fwd_data,
      .remap_mode, .remap_sel, .remap_pattern, .remap_base,
      .out_valid, .out_addr, .out_data
   );

endmodule

//--- verification/erx_regs_tb.sv
// ##########################################################################
// erx register block testbench
// table of host, link and status operations against a small remap model
// ##########################################################################

module erx_regs_tb;

   localparam logic [11:0] link_chip = 12'h810;
   localparam logic [3:0]  reg_group = 4'h0;
   localparam logic [8:0]  gpio_pins = 9'h15A;

   typedef enum {op_wr, op_rd, op_rdacc, op_pkt, op_lwr, op_both, op_stat, op_taps} op_t;

   logic              clk, nreset;
   logic              wb_cyc, wb_stb, wb_we, wb_ack;
   erx_pkg::mi_addr_t wb_adr;
   erx_pkg::data_t    wb_dat_i, wb_dat_o;
   logic              pkt_valid, pkt_ready, out_valid, load_taps;
   erx_pkg::addr_t    pkt_addr, out_addr;
   erx_pkg::data_t    pkt_data, out_data;
   logic [8:0]        gpio_datain;
   logic [15:0]       rx_status;
   erx_pkg::tap_t     idelay_value;

   // stimulus table, one entry per row in every queue
   op_t               row_op[$];
   string             row_name[$];
   logic [31:0]       row_addr[$];
   logic [31:0]       row_data[$];
   logic [63:0]       row_exp[$];   // both: {link address, link data}
   int                n_rows;

   logic [31:0]       exp_addr_q[$];  // pending output packets
   logic [31:0]       exp_data_q[$];
   string             exp_name_q[$];
   string             out_name;
   logic [31:0]       model_cfg, model_offset, test_sum;
   logic [31:0]       rng, rdata;
   int                checks, errors, tap_loads;

   erx_regs_top #(.chip_id(link_chip), .group(reg_group), .rfaw(6)) erx_regs_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ########################################################################
   // helpers
   // ########################################################################
   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERR %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic void add_row(op_t op, string name, logic [31:0] addr,
                                   logic [31:0] data, logic [63:0] exp);
      row_op.push_back(op);
      row_name.push_back(name);
      row_addr.push_back(addr);
      row_data.push_back(data);
      row_exp.push_back(exp);
   endfunction

   // model only tracks what shapes the output path and the accumulator
   function automatic void note_write(logic [14:0] addr, logic [31:0] data);
      if (addr[11:8] == reg_group) begin
         case (addr[7:2])
            6'd0: model_cfg = data;
            6'd1: model_offset = data;
            6'd4: test_sum = '0;   // accumulation restarts from the load
            default: ;
         endcase
      end
   endfunction

   // remap rules applied bit by bit
   function automatic logic [31:0] remap_addr(logic [31:0] a);
      logic [31:0] r;
      r = a;
      case (model_cfg[3:2])
         2'd1: begin
            for (int b = 0; b < 12; b++)
               if (model_cfg[4+b])
                  r[20+b] = model_cfg[16+b];
         end
         2'd2: r = a + model_offset;
         default: ;
      endcase
      return r;
   endfunction

   task automatic wait_ack(output logic [31:0] rd);
      do @(negedge clk); while (!wb_ack);
      rd = wb_dat_o;           // valid in the ack cycle
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   task automatic wb_cycle(input logic we, input logic [31:0] adr,
                           input logic [31:0] dat, output logic [31:0] rd);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr[14:0];
      wb_dat_i <= dat;
      wait_ack(rd);
   endtask

   task automatic drive_packet(input logic [31:0] adr, input logic [31:0] dat);
      pkt_valid <= 1'b1;
      pkt_addr  <= adr;
      pkt_data  <= dat;
      do @(negedge clk); while (!pkt_ready);
      @(posedge clk);          // transfer edge
      pkt_valid <= 1'b0;
   endtask

   task automatic send_packet(input logic [31:0] adr, input logic [31:0] dat);
      @(posedge clk);
      drive_packet(adr, dat);
   endtask

   // host write and link register write launched on the same edge
   task automatic write_both(input logic [31:0] hadr, input logic [31:0] hdat,
                             input logic [31:0] ladr, input logic [31:0] ldat);
      logic [31:0] rd;
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b1;
      wb_adr   <= hadr[14:0];
      wb_dat_i <= hdat;
      drive_packet(ladr, ldat);
      wait_ack(rd);
   endtask

   task automatic pulse_status(input logic [15:0] bits);
      @(posedge clk);
      rx_status <= bits;
      @(posedge clk);
      rx_status <= '0;
   endtask

   // ########################################################################
   // stimulus table
   // ########################################################################
   task automatic build_table();
      add_row(op_rd,    "rst_cfg",      32'h0000, 32'h0, 'h0);
      add_row(op_rd,    "rst_offset",   32'h0004, 32'h0, 'h0);
      add_row(op_rd,    "rst_idelay0",  32'h0008, 32'h0, 'h0);
      add_row(op_rd,    "rst_idelay1",  32'h000C, 32'h0, 'h0);
      add_row(op_rd,    "rst_testdata", 32'h0010, 32'h0, 'h0);
      add_row(op_rd,    "rst_status",   32'h0014, 32'h0, 'h0);
      add_row(op_rd,    "rst_gpio",     32'h0018, 32'h0, 'h15A);
      add_row(op_wr,    "hole_wr",      32'h001C, 32'hDEAD_BEEF, 'h0);
      add_row(op_rd,    "hole_rd",      32'h001C, 32'h0, 'h0);
      add_row(op_wr,    "grp_wr",       32'h0100, 32'hFFFF_FFFF, 'h0);  // group 1 cfg
      add_row(op_rd,    "grp_cfg",      32'h0000, 32'h0, 'h0);
      add_row(op_wr,    "cfg_wr",       32'h0000, 32'h5A3C_F0F0, 'h0);
      add_row(op_rd,    "cfg_rd",       32'h0000, 32'h0, 'h5A3C_F0F0);
      add_row(op_rd,    "grp_rd",       32'h0100, 32'h0, 'h0);  // group 0 cfg is nonzero
      add_row(op_wr,    "offset_wr",    32'h0004, 32'h1234_5678, 'h0);
      add_row(op_rd,    "offset_rd",    32'h0004, 32'h0, 'h1234_5678);
      add_row(op_wr,    "testdata_wr",  32'h0010, 32'hA5A5_0001, 'h0);
      add_row(op_rd,    "testdata_rd",  32'h0010, 32'h0, 'hA5A5_0001);
      add_row(op_lwr,   "link_wr",      32'h8100_0010, 32'h0BAD_F00D, 'h0);
      add_row(op_rd,    "link_rd",      32'h0010, 32'h0, 'h0BAD_F00D);
      add_row(op_both,  "both_wr",      32'h0004, 32'h1111_2222, {32'h8100_0010, 32'h3333_4444});
      add_row(op_rd,    "both_host",    32'h0004, 32'h0, 'h1111_2222);
      add_row(op_rd,    "both_link",    32'h0010, 32'h0, 'h3333_4444);
      // remap none, chip-id packets stay off the output
      add_row(op_wr,    "m0_cfg",       32'h0000, 32'h0000_0000, 'h0);
      add_row(op_pkt,   "m0_a",         32'h1234_5678, 32'h0, 'h0);
      add_row(op_pkt,   "m0_b",         32'h8110_0020, 32'h0, 'h0);
      add_row(op_lwr,   "m0_chip",      32'h8100_0018, 32'h0000_01FF, 'h0);  // gpio is read only
      add_row(op_rd,    "m0_gpio",      32'h0018, 32'h0, 'h15A);
      // static bit select, sel 0xf0f pattern 0xa5c
      add_row(op_wr,    "m1_cfg",       32'h0000, 32'h0A5C_F0F4, 'h0);
      add_row(op_pkt,   "m1_a",         32'h1234_5678, 32'h0, 'h0);
      add_row(op_pkt,   "m1_b",         32'hFFF0_0004, 32'h0, 'h0);
      // dynamic base, second packet wraps
      add_row(op_wr,    "m2_offset",    32'h0004, 32'hF000_1000, 'h0);
      add_row(op_wr,    "m2_cfg",       32'h0000, 32'h0000_0008, 'h0);
      add_row(op_pkt,   "m2_a",         32'h1234_5678, 32'h0, 'h0);
      add_row(op_pkt,   "m2_b",         32'h2000_F000, 32'h0, 'h0);
      add_row(op_lwr,   "m2_chip",      32'h8100_001C, 32'h0000_0055, 'h0);
      add_row(op_wr,    "m3_cfg",       32'h0000, 32'h0000_000C, 'h0);
      add_row(op_pkt,   "m3_a",         32'h4321_0000, 32'h0, 'h0);
      // test mode accumulates across the 2^32 wrap
      add_row(op_wr,    "tm_load",      32'h0010, 32'hFFFF_FFF0, 'h0);
      add_row(op_wr,    "tm_cfg",       32'h0000, 32'h0000_0001, 'h0);
      add_row(op_pkt,   "tm_a",         32'h0000_1000, 32'h0, 'h0);
      add_row(op_pkt,   "tm_b",         32'h7FFF_0000, 32'h0, 'h0);
      add_row(op_pkt,   "tm_c",         32'hC000_0040, 32'h0, 'h0);
      add_row(op_pkt,   "tm_d",         32'h0123_4567, 32'h0, 'h0);
      add_row(op_rdacc, "tm_sum",       32'h0010, 32'h0, 'hFFFF_FFF0);
      add_row(op_wr,    "tm_off",       32'h0000, 32'h0000_0000, 'h0);
      // sticky status
      add_row(op_stat,  "st_a",         32'h0, 32'h0000_0003, 'h0);
      add_row(op_stat,  "st_b",         32'h0, 32'h0000_0100, 'h0);
      add_row(op_rd,    "st_or",        32'h0014, 32'h0, 'h0103);
      add_row(op_wr,    "st_wr",        32'h0014, 32'h0000_0040, 'h0);
      add_row(op_rd,    "st_rd",        32'h0014, 32'h0, 'h0040);
      // delay taps, expectation packed by hand
      add_row(op_wr,    "tap0_wr",      32'h0008, 32'h7654_3210, 'h0);
      add_row(op_wr,    "tap1_wr",      32'h000C, 32'h0000_1A5B, 'h0);
      add_row(op_taps,  "tap_value",    32'h0, 32'h0, 64'h0000_1BB9_AA41_C830);
      n_rows = row_op.size();
   endtask

   // ########################################################################
   // output and strobe monitor
   // ########################################################################
   always @(negedge clk) begin
      if (nreset && load_taps)
         tap_loads++;
      if (nreset && out_valid) begin
         if (exp_addr_q.size() == 0) begin
            errors++;
            $display("output packet to %h appeared with none expected", out_addr);
         end else begin
            out_name = exp_name_q.pop_front();
            compare({out_name, "_addr"}, 64'(exp_addr_q.pop_front()), 64'(out_addr));
            compare({out_name, "_data"}, 64'(exp_data_q.pop_front()), 64'(out_data));
         end
      end
   end

   // watchdog scaled to the table length
   initial begin
      wait (n_rows != 0);
      repeat (200 * (n_rows + 1)) @(posedge clk);
      $display("timeout after %0d rows, the DUT stopped responding", n_rows);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      nreset = 1'b0;
      {wb_cyc, wb_stb, wb_we} = '0;
      wb_adr = '0;
      wb_dat_i = '0;
      pkt_valid = 1'b0;
      pkt_addr = '0;
      pkt_data = '0;
      gpio_datain = gpio_pins;
      rx_status = '0;
      {model_cfg, model_offset, test_sum} = '0;
      rng = 32'd41;
      {checks, errors, tap_loads} = '0;
      build_table();
      repeat (10) @(posedge clk);
      nreset <= 1'b1;

      for (int i = 0; i < n_rows; i++) begin
         case (row_op[i])
            op_wr: begin
               wb_cycle(1'b1, row_addr[i], row_data[i], rdata);
               note_write(row_addr[i][14:0], row_data[i]);
            end
            op_rd: begin
               wb_cycle(1'b0, row_addr[i], '0, rdata);
               compare(row_name[i], row_exp[i], 64'(rdata));
            end
            op_rdacc: begin
               wb_cycle(1'b0, row_addr[i], '0, rdata);
               compare(row_name[i], 64'(32'(row_exp[i][31:0] + test_sum)), 64'(rdata));
            end
            op_pkt: begin
               rng = xorshift(rng);
               if (model_cfg[0])
                  test_sum = test_sum + rng;   // swallowed into testdata
               else begin
                  exp_addr_q.push_back(remap_addr(row_addr[i]));
                  exp_data_q.push_back(rng);
                  exp_name_q.push_back(row_name[i]);
               end
               send_packet(row_addr[i], rng);
            end
            op_lwr: begin
               note_write(row_addr[i][14:0], row_data[i]);
               send_packet(row_addr[i], row_data[i]);
            end
            op_both: begin
               note_write(row_addr[i][14:0], row_data[i]);
               note_write(row_exp[i][46:32], row_exp[i][31:0]);
               write_both(row_addr[i], row_data[i], row_exp[i][63:32], row_exp[i][31:0]);
            end
            op_stat: pulse_status(row_data[i][15:0]);
            op_taps: begin
               @(negedge clk);
               compare(row_name[i], row_exp[i], 64'(idelay_value));
               compare({row_name[i], "_loads"}, 64'd1, 64'(tap_loads));
            end
            default: ;
         endcase
      end

      repeat (5) @(posedge clk);
      if (exp_addr_q.size() != 0) begin
         errors++;
         $display("%0d expected output packets never appeared", exp_addr_q.size());
      end
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

//--- erx_regs.f
verilog/erx_pkg.sv
verilog/erx_wb_bridge.sv
verilog/erx_pkt_access.sv
verilog/erx_mi_arbiter.sv
verilog/erx_cfg.sv
verilog/erx_remap.sv
verilog/erx_regs_top.sv
verification/erx_regs_tb.sv

//--- Makefile
# Verilator flow for the erx register block

VERILATOR ?= verilator
FILELIST  ?= erx_regs.f
TB_TOP    ?= erx_regs_tb
RTL_TOP   ?= erx_regs_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
SIM_FLAGS ?= --binary -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
